//--- logic/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

	// cache geometry
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;
	localparam int INDEX_W = 6;
	localparam int OFFSET_W = 4;
	localparam int TAG_W = 22;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = 128;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// one-hot or empty, bit n is way n
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE-1:0][LINE_W/WORDS_PER_LINE-1:0] line_t;

	// address as the cache sees it
	typedef struct packed {
		tag_t tag;
		index_t index;
		logic [1:0] word;
		logic [1:0] byte_sel;
	} cache_view_t;

	// address as the read bus sees it
	typedef struct packed {
		logic [TAG_W+INDEX_W-1:0] line;
		logic [OFFSET_W-1:0] byte_in_line;
	} bus_view_t;

	typedef union packed {
		cache_view_t cache;
		bus_view_t bus;
	} fetch_addr_u;

endpackage

`default_nettype wire

//--- logic/mem_rd_pkg.sv
`default_nettype none

package mem_rd_pkg;

	// beats per line refill
	localparam int BURST_BEATS = 4;

	// one read data beat
	typedef struct packed {
		logic [31:0] data;
		logic last;
	} r_beat_t;

	// one-hot position of a beat inside the line
	typedef logic [BURST_BEATS-1:0] beat_mask_t;

endpackage

`default_nettype wire

//--- logic/icache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
	import icache_cfg_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire fetch_addr_u lookup_addr,
	output way_mask_t hit_ways,
	input wire refill_done,
	input wire way_mask_t refill_way,
	input wire fetch_addr_u refill_addr,
	input wire inval_valid,
	input wire fetch_addr_u inval_addr
);

	tag_t tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid [NUM_WAYS];
	index_t lookup_index;
	index_t refill_index;
	index_t inval_index;
	way_mask_t inval_ways;

	assign lookup_index = lookup_addr.cache.index;
	assign refill_index = refill_addr.cache.index;
	assign inval_index = inval_addr.cache.index;

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_ways[w] = valid[w][lookup_index] && tags[w][lookup_index] == lookup_addr.cache.tag;
		end
	end

	// ways to clear, against the tag each way holds after this edge
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (refill_done && refill_way[w] && refill_index == inval_index) begin
				// way is being refilled, only the new tag counts
				inval_ways[w] = inval_valid && refill_addr.cache.tag == inval_addr.cache.tag;
			end else begin
				inval_ways[w] = inval_valid && tags[w][inval_index] == inval_addr.cache.tag;
			end
		end
	end

	// tag written with the last refill beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (refill_done && refill_way[w]) begin
				tags[w][refill_index] <= refill_addr.cache.tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (refill_done && refill_way[w]) begin
					valid[w][refill_index] <= 1'b1;
				end
				// later write wins, so invalidate beats refill
				if (inval_ways[w]) begin
					valid[w][inval_index] <= 1'b0;
				end
			end
		end
	end

	// a line is never filled twice into one set
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_ways));

	a_refill_way_onehot: assert property (@(posedge clk) disable iff (rst)
		refill_done |-> $onehot(refill_way));

endmodule

`default_nettype wire

//--- logic/icache_way_data.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way_data
	import icache_cfg_pkg::*;
	import mem_rd_pkg::*;
(
	input wire clk,
	input wire rd_en,
	input wire index_t rd_index,
	output line_t [NUM_WAYS-1:0] rd_lines,
	input wire way_mask_t wr_way,
	input wire beat_mask_t wr_beat,
	input wire index_t wr_index,
	input wire [31:0] wr_word
);

	// one line array per way, models the SRAM macros
	line_t lines [NUM_WAYS][NUM_SETS];

	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			// word write, the beat mask picks the slot in the line
			for (int b = 0; b < BURST_BEATS; b++) begin
				if (wr_way[w] && wr_beat[b]) begin
					lines[w][wr_index][b] <= wr_word;
				end
			end
			// registered read of all ways at once
			if (rd_en) begin
				rd_lines[w] <= lines[w][rd_index];
			end
		end
	end

	// the controller steers each beat to exactly one way and slot
	a_wr_onehot: assert property (@(posedge clk)
		(|wr_way || |wr_beat) |-> ($onehot(wr_way) && $onehot(wr_beat)));

endmodule

`default_nettype wire

//--- logic/icache_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl
	import icache_cfg_pkg::*;
	import mem_rd_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire fetch_addr_u fetch_addr,
	input wire flush,
	input wire way_mask_t hit_ways,
	input wire line_t [NUM_WAYS-1:0] rd_lines,
	output logic rd_en,
	output index_t rd_index,
	output way_mask_t wr_way,
	output beat_mask_t wr_beat,
	output index_t wr_index,
	output logic [31:0] wr_word,
	output logic refill_done,
	output way_mask_t refill_way,
	output fetch_addr_u refill_addr,
	output logic ar_valid,
	output logic [TAG_W+INDEX_W-1:0] ar_addr,
	input wire ar_ready,
	input wire r_valid,
	input wire r_beat_t r_beat,
	output logic ready,
	output logic [31:0] inst,
	output logic hit
);

	typedef enum logic {st_idle, st_refill} state_t;

	state_t state;
	fetch_addr_u miss_addr;
	way_mask_t rr_ptr;
	way_mask_t victim;
	way_mask_t hit_way_q;
	beat_mask_t beat_pos;
	logic [1:0] word_q;
	logic req_live;
	logic beat_in;

	// the request is still held during its ready cycle
	assign req_live = fetch_valid && !ready;
	assign hit = state == st_idle && req_live && |hit_ways;
	assign ar_valid = state == st_idle && req_live && hit_ways == '0;
	assign ar_addr = fetch_addr.bus.line;

	// data store read on a hit
	assign rd_en = hit;
	assign rd_index = fetch_addr.cache.index;

	// refill writes, one word per beat
	assign beat_in = state == st_refill && r_valid;
	assign wr_way = beat_in ? victim : '0;
	assign wr_beat = beat_in ? beat_pos : '0;
	assign wr_index = miss_addr.cache.index;
	assign wr_word = r_beat.data;
	assign refill_done = beat_in && r_beat.last;
	assign refill_way = victim;
	assign refill_addr = miss_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			rr_ptr <= way_mask_t'(1);
			beat_pos <= beat_mask_t'(1);
			ready <= 1'b0;
		end else begin
			// flush cancels the response due next cycle
			ready <= hit && !flush;
			if (ar_valid && ar_ready) begin
				state <= st_refill;
				beat_pos <= beat_mask_t'(1);
			end else if (beat_in) begin
				beat_pos <= {beat_pos[BURST_BEATS-2:0], beat_pos[BURST_BEATS-1]};
				if (r_beat.last) begin
					state <= st_idle;
					// next victim only after a completed refill
					rr_ptr <= {rr_ptr[NUM_WAYS-2:0], rr_ptr[NUM_WAYS-1]};
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			miss_addr <= fetch_addr;
			victim <= rr_ptr;
		end
		if (hit) begin
			hit_way_q <= hit_ways;
			word_q <= fetch_addr.cache.word;
		end
	end

	// word select from the line read one cycle ago
	always_comb begin
		inst = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_way_q[w]) begin
				inst = rd_lines[w][word_q];
			end
		end
	end

	// memory only sends beats for a request it accepted
	a_rvalid_in_refill: assert property (@(posedge clk) disable iff (rst)
		r_valid |-> state == st_refill);

endmodule

`default_nettype wire

//--- logic/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
	import icache_cfg_pkg::*;
	import mem_rd_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire fetch_addr_u fetch_addr,
	input wire flush,
	input wire inval_valid,
	input wire fetch_addr_u inval_addr,
	output logic ready,
	output logic [31:0] inst,
	output logic hit,
	output logic ar_valid,
	output logic [TAG_W+INDEX_W-1:0] ar_addr,
	input wire ar_ready,
	input wire r_valid,
	input wire r_beat_t r_beat
);

	way_mask_t hit_ways;
	logic refill_done;
	way_mask_t refill_way;
	fetch_addr_u refill_addr;
	logic rd_en;
	index_t rd_index;
	line_t [NUM_WAYS-1:0] rd_lines;
	way_mask_t wr_way;
	beat_mask_t wr_beat;
	index_t wr_index;
	logic [31:0] wr_word;

	// tags and valid bits, looked up with the live fetch address
	icache_tag_store i_tag_store (
		.clk(clk),
		.rst(rst),
		.lookup_addr(fetch_addr),
		.hit_ways(hit_ways),
		.refill_done(refill_done),
		.refill_way(refill_way),
		.refill_addr(refill_addr),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr)
	);

	icache_way_data i_way_data (
		.clk(clk),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_lines(rd_lines),
		.wr_way(wr_way),
		.wr_beat(wr_beat),
		.wr_index(wr_index),
		.wr_word(wr_word)
	);

	icache_fetch_ctrl i_fetch_ctrl (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.flush(flush),
		.hit_ways(hit_ways),
		.rd_lines(rd_lines),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.wr_way(wr_way),
		.wr_beat(wr_beat),
		.wr_index(wr_index),
		.wr_word(wr_word),
		.refill_done(refill_done),
		.refill_way(refill_way),
		.refill_addr(refill_addr),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r_beat(r_beat),
		.ready(ready),
		.inst(inst),
		.hit(hit)
	);

endmodule

`default_nettype wire

//--- testbench/mem_burst_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_burst_model
	import icache_cfg_pkg::*;
	import mem_rd_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire ar_valid,
	input wire [TAG_W+INDEX_W-1:0] ar_addr,
	output logic ar_ready,
	output logic r_valid,
	output r_beat_t r_beat
);

	integer seed;
	logic [TAG_W+INDEX_W-1:0] line_q;

	// content of one memory word, mixed from its word address
	function automatic logic [31:0] mem_word(input logic [29:0] word_addr);
		logic [31:0] x;
		x = {2'b00, word_addr};
		return (x * 32'h9e3779b1) ^ (x >> 11) ^ 32'h0c3a5f17;
	endfunction

	initial begin
		seed = 32'h160c;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_beat = '0;
		forever begin
			@(posedge clk);
			if (!rst && ar_valid && ar_ready) begin
				// request taken at this edge, send the line in word order
				line_q = ar_addr;
				#10;
				ar_ready = 1'b0;
				for (int b = 0; b < BURST_BEATS; b++) begin
					// random idle cycles before each beat
					while ($random(seed) % 3 == 0) begin
						r_valid = 1'b0;
						@(posedge clk);
						#10;
					end
					r_valid = 1'b1;
					r_beat.data = mem_word({line_q, 2'(b)});
					r_beat.last = b == BURST_BEATS - 1;
					@(posedge clk);
					#10;
				end
				r_valid = 1'b0;
				r_beat = '0;
			end else begin
				#10;
				// ar_ready comes and goes at random
				ar_ready = !rst && $random(seed) % 2 == 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb
	import icache_cfg_pkg::*;
	import mem_rd_pkg::*;
();

	localparam int RANDOM_OPS = 300;
	localparam int DIRECTED_OPS = 40;
	// average budget per operation, then a safety factor
	localparam int CYCLES_PER_OP = 12;
	localparam int MARGIN = 4;
	localparam int FETCH_LIMIT = 200;
	localparam int DRIVE_DELAY = 10;

	logic clk;
	logic rst;
	logic fetch_valid;
	fetch_addr_u fetch_addr;
	logic flush;
	logic inval_valid;
	fetch_addr_u inval_addr;
	logic ready;
	logic [31:0] inst;
	logic hit;
	logic ar_valid;
	logic [TAG_W+INDEX_W-1:0] ar_addr;
	logic ar_ready;
	logic r_valid;
	r_beat_t r_beat;

	// reference model, tags and valid bits per set plus the global victim pointer
	tag_t ref_tags [NUM_SETS][NUM_WAYS];
	logic ref_valid [NUM_SETS][NUM_WAYS];
	int rr_way;
	integer seed;
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	int num_tests;

	icache i_icache (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.flush(flush),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr),
		.ready(ready),
		.inst(inst),
		.hit(hit),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r_beat(r_beat)
	);

	mem_burst_model i_mem (
		.clk(clk),
		.rst(rst),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r_beat(r_beat)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat ((RANDOM_OPS + DIRECTED_OPS) * CYCLES_PER_OP * MARGIN) @(posedge clk);
		$display("watchdog expired, the simulation hung");
		$display("Errors found");
		$finish;
	end

	task automatic check_inst(input fetch_addr_u a, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: inst for %h is %h, expected %h", $time, a, got, exp);
		end
	endtask

	task automatic check_hit(input fetch_addr_u a, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: hit for %h is %b, expected %b", $time, a, got, exp);
		end
	endtask

	// address only matters when a request is expected
	task automatic check_request(input fetch_addr_u a, input logic got_valid,
		input logic [TAG_W+INDEX_W-1:0] got_addr, input logic exp_valid);
		checks++;
		if (got_valid !== exp_valid || (exp_valid && got_addr !== a.bus.line)) begin
			errors++;
			$display("FAILED %0t: ar_valid %b ar_addr %h for %h, expected %b", $time,
				got_valid, got_addr, a, exp_valid);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: ready is %b %s, expected %b", $time, got, what, exp);
		end
	endtask

	function automatic fetch_addr_u make_addr(input tag_t tag, input index_t idx,
		input logic [1:0] word);
		fetch_addr_u a;
		a.cache.tag = tag;
		a.cache.index = idx;
		a.cache.word = word;
		a.cache.byte_sel = 2'b00;
		return a;
	endfunction

	// six tags over three sets, more tags than ways
	function automatic fetch_addr_u random_addr();
		int t;
		int s;
		t = ($random(seed) & 32'h7fffffff) % 6;
		s = ($random(seed) & 32'h7fffffff) % 3;
		return make_addr(22'h0a5a0 + tag_t'(t), index_t'(s), 2'($random(seed)));
	endfunction

	function automatic int ref_lookup(input fetch_addr_u a);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[a.cache.index][w] && ref_tags[a.cache.index][w] == a.cache.tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic run_fetch(input fetch_addr_u a);
		int exp_way;
		int cycles;
		exp_way = ref_lookup(a);
		fetch_valid = 1'b1;
		fetch_addr = a;
		@(negedge clk);
		check_hit(a, hit, exp_way >= 0);
		check_request(a, ar_valid, ar_addr, exp_way < 0);
		cycles = 0;
		while (ready !== 1'b1 && cycles < FETCH_LIMIT) begin
			@(negedge clk);
			cycles++;
			// a hit answers in the very next cycle
			if (exp_way >= 0 && cycles == 1) begin
				check_ready(ready, 1'b1, "one cycle after a hit");
			end
		end
		if (ready !== 1'b1) begin
			errors++;
			$display("no ready for the fetch of %h within %0d cycles", a, FETCH_LIMIT);
		end else begin
			check_inst(a, inst, i_mem.mem_word({a.bus.line, a.cache.word}));
		end
		if (exp_way < 0) begin
			ref_tags[a.cache.index][rr_way] = a.cache.tag;
			ref_valid[a.cache.index][rr_way] = 1'b1;
			rr_way = (rr_way + 1) % NUM_WAYS;
		end
		next_cycle();
		fetch_valid = 1'b0;
	endtask

	// flush together with a hit request, then the request is dropped
	task automatic run_flushed_fetch(input fetch_addr_u a);
		fetch_valid = 1'b1;
		fetch_addr = a;
		flush = 1'b1;
		@(negedge clk);
		check_hit(a, hit, 1'b1);
		next_cycle();
		fetch_valid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		check_ready(ready, 1'b0, "after flush");
		next_cycle();
	endtask

	task automatic run_inval(input fetch_addr_u a);
		inval_valid = 1'b1;
		inval_addr = a;
		next_cycle();
		inval_valid = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_tags[a.cache.index][w] == a.cache.tag) begin
				ref_valid[a.cache.index][w] = 1'b0;
			end
		end
	endtask

	task automatic end_test(input string name);
		num_tests++;
		$display("test %s: %0d checks, %0d mismatches", name, checks - test_checks,
			errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	initial begin
		int r;
		fetch_addr_u a;
		fetch_addr_u conflict [5];
		seed = 32'h160c;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		inval_valid = 1'b0;
		inval_addr = '0;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		num_tests = 0;
		rr_way = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
			end
		end
		repeat (4) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;

		// quiet outputs until the first request
		repeat (5) begin
			@(negedge clk);
			check_ready(ready, 1'b0, "after reset");
			check_request(fetch_addr, ar_valid, ar_addr, 1'b0);
		end
		next_cycle();
		end_test("reset");

		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = ($random(seed) & 32'h7fffffff) % 10;
			a = random_addr();
			if (r == 0) begin
				run_inval(a);
			end else if (r == 1 && ref_lookup(a) >= 0) begin
				run_flushed_fetch(a);
			end else begin
				run_fetch(a);
			end
		end
		end_test("random");

		a = make_addr(22'h3c0100, 6'd42, 2'd1);
		run_fetch(a);
		run_fetch(a);
		a.cache.word = 2'd3;
		run_fetch(a);
		end_test("refetch");

		// four fills stay resident, the fifth takes the round-robin way
		for (int k = 0; k < 5; k++) begin
			conflict[k] = make_addr(22'h3c0200 + tag_t'(k), 6'd50, 2'(k));
		end
		for (int k = 0; k < 4; k++) begin
			run_fetch(conflict[k]);
		end
		for (int k = 0; k < 4; k++) begin
			run_fetch(conflict[k]);
		end
		run_fetch(conflict[4]);
		for (int k = 1; k < 4; k++) begin
			run_fetch(conflict[k]);
		end
		run_fetch(conflict[0]);
		end_test("conflict");

		a = make_addr(22'h3c0300, 6'd40, 2'd2);
		run_fetch(a);
		run_fetch(a);
		run_inval(a);
		run_fetch(a);
		// absent line, set contents unchanged
		run_inval(make_addr(22'h3c0301, 6'd40, 2'd0));
		run_fetch(a);
		end_test("invalidate");

		a = make_addr(22'h3c0400, 6'd41, 2'd0);
		run_fetch(a);
		run_flushed_fetch(a);
		run_fetch(a);
		end_test("flush");

		$display("summary: %0d tests, %0d checks, %0d mismatches", num_tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/icache_cfg_pkg.sv
logic/mem_rd_pkg.sv
logic/icache_tag_store.sv
logic/icache_way_data.sv
logic/icache_fetch_ctrl.sv
logic/icache.sv
testbench/mem_burst_model.sv
testbench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - logic/icache_cfg_pkg.sv
      - logic/mem_rd_pkg.sv
  - files:
      - logic/icache_tag_store.sv
      - logic/icache_way_data.sv
      - logic/icache_fetch_ctrl.sv
      - logic/icache.sv
  - target: test
    files:
      - testbench/mem_burst_model.sv
      - testbench/icache_tb.sv
